// ==== common/bus_pkg.sv ====
// Internal memory bus widths
// Slot arbitration constants for the RAM window
// Access timing of the external SRAM

package bus_pkg;

    // Address and data sizes
    localparam int RAM_ADDR_WIDTH = 17;  // 128 KiB of byte-wide SRAM
    localparam int DATA_WIDTH     = 8;

    // Slot counter, one RAM slot per frame
    localparam int SLOT_BITS = 6;  // 64-cycle frame
    localparam logic [SLOT_BITS-1:0] SLOT_GRANT = SLOT_BITS'(63);

    // Cycles the RAM pins stay asserted for one access
    localparam int RAM_ACCESS_CYCLES = 2;

    // Width of the access hold counter
    localparam int ACCESS_CNT_BITS = $clog2(RAM_ACCESS_CYCLES + 1);

endpackage

// ==== common/spi_cmd_pkg.sv ====
// SPI command frame layout
// Bit positions inside the command byte
// State type of the command decoder

package spi_cmd_pkg;

    // Command byte fields
    localparam int CMD_WRITE_BIT = 7;  // 1 = write frame
    localparam int CMD_A16_BIT   = 0;  // Top RAM address bit

    // Where the frame bytes land in the RAM address
    localparam int ADDR_A16_POS = 16;
    localparam int ADDR_HI_LSB  = 8;   // Byte 1 carries bits 15..8

    // Bit counter within one SPI byte
    localparam int BIT_CNT_BITS = 3;

    // Decoder states, one per frame byte plus the bus wait
    typedef enum logic [2:0] {
        COMMAND,
        ADDR_HI,
        ADDR_LO,
        DATA,
        WAIT_ACK,
        DONE
    } decode_state_t;

endpackage

// ==== common/mem_bus_if.sv ====
// Internal single-byte memory bus
// Cycle, strobe, stall and ack handshake with address and data
// Modports for the decoder, both arbiter sides and the SRAM controller

interface mem_bus_if import bus_pkg::*; ();

    logic [RAM_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     wdata;
    logic [DATA_WIDTH-1:0]     rdata;
    logic                      we;
    logic                      cycle;
    logic                      strobe;
    logic                      stall;   // Strobe not yet taken
    logic                      ack;     // One-cycle completion pulse

    // Request side, the command decoder
    modport master (
        output addr, wdata, we, cycle, strobe,
        input  rdata, stall, ack
    );

    // Arbiter facing the requester
    modport arb_in (
        input  addr, wdata, we, cycle, strobe,
        output rdata, stall, ack
    );

    // Arbiter facing the RAM
    modport arb_out (
        output addr, wdata, we, cycle, strobe,
        input  rdata, stall, ack
    );

    modport target (
        input  addr, wdata, we, cycle, strobe,
        output rdata, stall, ack
    );

endinterface

// ==== rtl/spi/spi_target.sv ====
// SPI mode 0 target
// Two-flop pin synchronizers and SCK edge detection
// Receive shifter with byte strobe, reply shifter on falling edges

module spi_target import bus_pkg::*, spi_cmd_pkg::*; (
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  logic                  spi_cs_n_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_sd_i,
    output logic                  spi_sd_o,
    output logic                  rx_valid_o,
    output logic [DATA_WIDTH-1:0] rx_byte_o,
    output logic                  frame_start_o,
    input  logic                  tx_load_i,
    input  logic [DATA_WIDTH-1:0] tx_byte_i
);

    logic [2:0]              cs_ff;     // [1] synchronized, [2] previous
    logic [2:0]              sck_ff;
    logic [1:0]              sd_ff;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    sd_bit;    // Data aligned with sck_rise
    logic                    byte_done;
    logic [BIT_CNT_BITS-1:0] bit_cnt;
    logic [DATA_WIDTH-1:0]   rx_shift;
    logic [DATA_WIDTH-1:0]   tx_shift;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cs_ff         <= '1;        // Idle deselected
            sck_ff        <= '0;
            sd_ff         <= '0;
            sck_rise      <= 1'b0;
            sck_fall      <= 1'b0;
            sd_bit        <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            cs_ff         <= {cs_ff[1:0], spi_cs_n_i};
            sck_ff        <= {sck_ff[1:0], spi_sck_i};
            sd_ff         <= {sd_ff[0], spi_sd_i};
            sck_rise      <= sck_ff[1] & ~sck_ff[2] & ~cs_ff[1];
            sck_fall      <= ~sck_ff[1] & sck_ff[2] & ~cs_ff[1];
            sd_bit        <= sd_ff[1];
            frame_start_o <= ~cs_ff[1] & cs_ff[2];  // Chip select just fell
        end
    end

    // Bit counting and byte strobe
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt    <= '0;
            byte_done  <= 1'b0;
            rx_valid_o <= 1'b0;
        end else begin
            if (cs_ff[1]) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;          // Wraps after eight bits
            end
            byte_done  <= sck_rise && !cs_ff[1] && (bit_cnt == '1);
            rx_valid_o <= byte_done;
        end
    end

    always_ff @(posedge clock_i) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[DATA_WIDTH-2:0], sd_bit};  // MSB first
        end
        if (byte_done) begin
            rx_byte_o <= rx_shift;
        end
    end

    // Reply path
    // The falling edge that closes a byte is skipped so a byte loaded
    // between bytes keeps its MSB on the line
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_shift <= '0;
        end else if (tx_load_i) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall && bit_cnt != '0) begin
            tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_shift[DATA_WIDTH-1];

endmodule

// ==== rtl/spi/spi_cmd_decoder.sv ====
// SPI frame decoder
// Collects command, address and write data bytes
// Issues one bus request per frame and returns read data as the reply byte

module spi_cmd_decoder import bus_pkg::*, spi_cmd_pkg::*; (
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  logic                  rx_valid_i,
    input  logic [DATA_WIDTH-1:0] rx_byte_i,
    input  logic                  frame_start_i,
    output logic                  tx_load_o,
    output logic [DATA_WIDTH-1:0] tx_byte_o,
    output logic                  spi_stall_o,
    mem_bus_if.master             bus
);

    decode_state_t state;
    logic          accepted;   // Strobe taken by the arbiter
    logic          restart;    // New frame seen during the bus wait
    logic          done_ack;

    assign done_ack = (state == WAIT_ACK) && bus.ack && accepted;

    // Reply byte goes straight into the SPI shifter on a read ack
    assign tx_load_o = done_ack && !bus.we;
    assign tx_byte_o = bus.rdata;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= COMMAND;
            bus.cycle   <= 1'b0;
            bus.strobe  <= 1'b0;
            spi_stall_o <= 1'b0;
            accepted    <= 1'b0;
            restart     <= 1'b0;
        end else begin
            if (bus.strobe && !bus.stall) begin
                accepted <= 1'b1;
            end
            if (frame_start_i && state != WAIT_ACK) begin
                state <= COMMAND;
            end else begin
                unique case (state)
                    COMMAND: if (rx_valid_i) state <= ADDR_HI;
                    ADDR_HI: if (rx_valid_i) state <= ADDR_LO;
                    ADDR_LO, DATA: begin
                        // Reads go out after the address, writes after the data
                        if (rx_valid_i && (state == DATA || !bus.we)) begin
                            bus.cycle   <= 1'b1;
                            bus.strobe  <= 1'b1;
                            spi_stall_o <= 1'b1;
                            accepted    <= 1'b0;
                            state       <= WAIT_ACK;
                        end else if (rx_valid_i) begin
                            state <= DATA;
                        end
                    end
                    WAIT_ACK: begin
                        if (frame_start_i) restart <= 1'b1;
                        if (done_ack) begin
                            bus.cycle   <= 1'b0;
                            bus.strobe  <= 1'b0;
                            spi_stall_o <= 1'b0;
                            restart     <= 1'b0;
                            state       <= (restart || frame_start_i) ? COMMAND : DONE;
                        end
                    end
                    default: ;  // DONE waits for the next frame
                endcase
            end
        end
    end

    // Request payload, held unchanged while the bus cycle is open
    always_ff @(posedge clock_i) begin
        if (rx_valid_i) begin
            unique case (state)
                COMMAND: begin
                    bus.we               <= rx_byte_i[CMD_WRITE_BIT];
                    bus.addr[ADDR_A16_POS] <= rx_byte_i[CMD_A16_BIT];
                end
                ADDR_HI: bus.addr[ADDR_HI_LSB +: DATA_WIDTH] <= rx_byte_i;
                ADDR_LO: bus.addr[DATA_WIDTH-1:0]            <= rx_byte_i;
                DATA:    bus.wdata                           <= rx_byte_i;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/bus/bus_arbiter.sv ====
// Slot arbiter between the decoder and the SRAM controller
// Free-running 64-cycle slot counter, RAM opened only at SLOT_GRANT

module bus_arbiter import bus_pkg::*; (
    input  logic       clock_i,
    input  logic       rst_n_i,
    mem_bus_if.arb_in  req,
    mem_bus_if.arb_out ram,
    output logic       bus_busy_o
);

    logic [SLOT_BITS-1:0] slot_cnt;
    logic                 slot_hit;
    logic                 granted;   // Access in flight on the RAM side
    logic                 take;

    assign slot_hit = (slot_cnt == SLOT_GRANT);
    assign take     = req.cycle && req.strobe && slot_hit && !granted && !ram.stall;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_cnt <= '0;
            granted  <= 1'b0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;   // Runs regardless of requests
            if (ram.ack) begin
                granted <= 1'b0;
            end else if (take) begin
                granted <= 1'b1;
            end
        end
    end

    // Payload passes straight through
    assign ram.addr  = req.addr;
    assign ram.wdata = req.wdata;
    assign ram.we    = req.we;

    // Strobe forwarded in the granted slot only
    assign ram.cycle  = req.cycle && (granted || slot_hit);
    assign ram.strobe = req.strobe && slot_hit && !granted;

    assign req.rdata = ram.rdata;
    assign req.ack   = ram.ack;
    assign req.stall = !(granted || (slot_hit && !ram.stall));

    assign bus_busy_o = req.cycle;

endmodule

// ==== rtl/bus/sram_controller.sv ====
// External SRAM controller
// Registers address and data, holds oe or we for RAM_ACCESS_CYCLES
// Samples read data in the last held cycle and pulses ack after it

module sram_controller import bus_pkg::*; (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    mem_bus_if.target                 bus,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [DATA_WIDTH-1:0]     ram_data_i,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o
);

    logic                       active;    // RAM pins asserted
    logic [ACCESS_CNT_BITS-1:0] hold_cnt;  // Remaining held cycles
    logic                       accept;

    assign accept    = bus.cycle && bus.strobe && !bus.stall;
    assign bus.stall = active || bus.ack;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active        <= 1'b0;
            hold_cnt      <= '0;
            bus.ack       <= 1'b0;
            bus.rdata     <= '0;
            ram_addr_o    <= '0;
            ram_data_o    <= '0;
            ram_data_oe_o <= 1'b0;
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (accept) begin
                ram_addr_o    <= bus.addr;
                ram_data_o    <= bus.wdata;
                ram_we_o      <= bus.we;
                ram_data_oe_o <= bus.we;   // Drive the data pins on writes only
                ram_oe_o      <= !bus.we;
                hold_cnt      <= ACCESS_CNT_BITS'(RAM_ACCESS_CYCLES - 1);
                active        <= 1'b1;
            end else if (active) begin
                if (hold_cnt != '0) begin
                    hold_cnt <= hold_cnt - 1'b1;
                end else begin
                    // Last held cycle, release the pins and complete
                    if (ram_oe_o) begin
                        bus.rdata <= ram_data_i;
                    end
                    ram_we_o      <= 1'b0;
                    ram_oe_o      <= 1'b0;
                    ram_data_oe_o <= 1'b0;
                    active        <= 1'b0;
                    bus.ack       <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/pet_bridge_top.sv ====
// Microcontroller to SRAM bridge, top level
// SPI target and command decoder on the request side
// Slot arbiter and SRAM controller on the RAM side

module pet_bridge_top import bus_pkg::*; (
    input  logic                      clock_i,
    input  logic                      rst_n_i,

    // SPI from the microcontroller
    input  logic                      spi_cs_n_i,
    input  logic                      spi_sck_i,
    input  logic                      spi_sd_i,
    output logic                      spi_sd_o,
    output logic                      spi_stall_o,   // Request in progress

    // External SRAM
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  logic [DATA_WIDTH-1:0]     ram_data_i,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_data_oe_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o,

    output logic                      status_o
);

    logic                  rx_valid;
    logic [DATA_WIDTH-1:0] rx_byte;
    logic                  frame_start;
    logic                  tx_load;
    logic [DATA_WIDTH-1:0] tx_byte;
    logic                  bus_busy;

    mem_bus_if req_bus ();   // Decoder to arbiter
    mem_bus_if ram_bus ();   // Arbiter to SRAM controller

    spi_target spi_target_i (
        .clock_i       (clock_i),
        .rst_n_i       (rst_n_i),
        .spi_cs_n_i    (spi_cs_n_i),
        .spi_sck_i     (spi_sck_i),
        .spi_sd_i      (spi_sd_i),
        .spi_sd_o      (spi_sd_o),
        .rx_valid_o    (rx_valid),
        .rx_byte_o     (rx_byte),
        .frame_start_o (frame_start),
        .tx_load_i     (tx_load),
        .tx_byte_i     (tx_byte)
    );

    spi_cmd_decoder spi_cmd_decoder_i (
        .clock_i       (clock_i),
        .rst_n_i       (rst_n_i),
        .rx_valid_i    (rx_valid),
        .rx_byte_i     (rx_byte),
        .frame_start_i (frame_start),
        .tx_load_o     (tx_load),
        .tx_byte_o     (tx_byte),
        .spi_stall_o   (spi_stall_o),
        .bus           (req_bus)
    );

    bus_arbiter bus_arbiter_i (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .req        (req_bus),
        .ram        (ram_bus),
        .bus_busy_o (bus_busy)
    );

    sram_controller sram_controller_i (
        .clock_i       (clock_i),
        .rst_n_i       (rst_n_i),
        .bus           (ram_bus),
        .ram_addr_o    (ram_addr_o),
        .ram_data_i    (ram_data_i),
        .ram_data_o    (ram_data_o),
        .ram_data_oe_o (ram_data_oe_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o)
    );

    assign status_o = bus_busy;  // LED on while a bus cycle is open

endmodule

// ==== verification/bridge_checker.sv ====
// Watches the bridge pins and compares them with expected frame values
// RAM access, stall, status and SPI reply checks with error counting

module bridge_checker import bus_pkg::*; (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic                      spi_cs_n_i,
    input  logic                      spi_sck_i,
    input  logic                      spi_sd_i,
    input  logic                      spi_stall_i,
    input  logic [RAM_ADDR_WIDTH-1:0] ram_addr_i,
    input  logic [DATA_WIDTH-1:0]     ram_data_i,
    input  logic                      ram_data_oe_i,
    input  logic                      ram_oe_i,
    input  logic                      ram_we_i,
    input  logic                      status_i,
    input  logic [1:0]                exp_kind_i,
    input  logic [RAM_ADDR_WIDTH-1:0] exp_addr_i,
    input  logic [DATA_WIDTH-1:0]     exp_wdata_i,
    input  logic [DATA_WIDTH-1:0]     exp_rdata_i,
    output int                        error_cnt_o,
    output int                        frame_cnt_o
);

    localparam logic [1:0] KIND_WRITE = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_ABORT = 2'd2;
    localparam int STALL_LIMIT = 70;

    logic       cs_q, sck_q, stall_q, we_q, oe_q;
    logic [7:0] reply;             // Last eight bits seen on spi_sd_o
    int         access_cnt, stall_rises, stall_len, hold_len, bit_cnt;
    int         errors = 0;
    int         frames = 0;

    assign error_cnt_o = errors;
    assign frame_cnt_o = frames;

    task automatic report_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    always @(posedge clock_i) begin
        if (!rst_n_i) begin
            if (spi_sd_i || spi_stall_i || ram_addr_i != '0 || ram_data_i != '0 ||
                ram_data_oe_i || ram_oe_i || ram_we_i || status_i)
                report_error("outputs not low during reset");
            {cs_q, sck_q, stall_q, we_q, oe_q} <= 5'b10000;
            access_cnt <= 0;
            stall_rises <= 0;
            stall_len <= 0;
            hold_len <= 0;
            bit_cnt <= 0;
        end else begin
            {cs_q, sck_q, stall_q, we_q, oe_q} <=
                {spi_cs_n_i, spi_sck_i, spi_stall_i, ram_we_i, ram_oe_i};
            if (ram_oe_i && ram_we_i) report_error("oe and we high together");
            if ((ram_oe_i || ram_we_i) && !status_i) report_error("status low during access");
            if (ram_we_i && (exp_kind_i != KIND_WRITE || ram_addr_i != exp_addr_i ||
                             ram_data_i != exp_wdata_i || !ram_data_oe_i))
                report_error($sformatf("write %h=%h, expected %h=%h", ram_addr_i,
                                       ram_data_i, exp_addr_i, exp_wdata_i));
            if (ram_oe_i && (exp_kind_i != KIND_READ || ram_addr_i != exp_addr_i ||
                             ram_data_oe_i))
                report_error($sformatf("read at %h, expected %h", ram_addr_i, exp_addr_i));
            if ((ram_we_i && !we_q) || (ram_oe_i && !oe_q)) access_cnt <= access_cnt + 1;
            if (ram_we_i || ram_oe_i) begin
                hold_len <= hold_len + 1;
            end else if (we_q || oe_q) begin
                if (hold_len != RAM_ACCESS_CYCLES)
                    report_error($sformatf("access held %0d cycles", hold_len));
                hold_len <= 0;
            end
            if (spi_stall_i) begin
                stall_len <= stall_len + 1;
                if (stall_len == STALL_LIMIT) report_error("stall high too long");
                if (!stall_q) stall_rises <= stall_rises + 1;
            end else begin
                stall_len <= 0;
            end
            if (spi_sck_i && !sck_q && !spi_cs_n_i) begin
                reply <= {reply[6:0], spi_sd_i};   // Mode 0, sampled on rising SCK
                bit_cnt <= bit_cnt + 1;
            end
            // End of frame
            if (spi_cs_n_i && !cs_q) begin
                if (access_cnt != (exp_kind_i == KIND_ABORT ? 0 : 1))
                    report_error($sformatf("%0d RAM accesses in frame", access_cnt));
                if (stall_rises != (exp_kind_i == KIND_ABORT ? 0 : 1))
                    report_error($sformatf("%0d stall pulses in frame", stall_rises));
                if (exp_kind_i == KIND_READ && (bit_cnt != 32 || reply != exp_rdata_i))
                    report_error($sformatf("reply %h, expected %h", reply, exp_rdata_i));
                frames = frames + 1;
                access_cnt <= 0;
                stall_rises <= 0;
                bit_cnt <= 0;
            end
        end
    end

endmodule

// ==== verification/tb_pet_bridge.sv ====
// Bridge testbench with clock, reset and SRAM model
// Stimulus table of frames driven over bit-banged SPI
// Cycle-count timeout

module tb_pet_bridge import bus_pkg::*; ;

    localparam int NUM_ENTRIES    = 10;
    localparam int HALF_SCK       = 8;   // Clocks per SCK half period
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 800 + 200;
    localparam logic [1:0] KIND_WRITE = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_ABORT = 2'd2;  // Chip select raised after byte 1

    logic                      clock_i;
    logic                      rst_n_i;
    logic                      spi_cs_n_i;
    logic                      spi_sck_i;
    logic                      spi_sd_i;
    logic                      spi_sd_o;
    logic                      spi_stall_o;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr_o;
    logic [DATA_WIDTH-1:0]     ram_data_i;
    logic [DATA_WIDTH-1:0]     ram_data_o;
    logic                      ram_data_oe_o;
    logic                      ram_oe_o;
    logic                      ram_we_o;
    logic                      status_o;

    logic [DATA_WIDTH-1:0]     sram   [0:2**RAM_ADDR_WIDTH-1];
    logic [DATA_WIDTH-1:0]     shadow [0:2**RAM_ADDR_WIDTH-1];  // Expected contents
    logic [1:0]                tbl_kind  [NUM_ENTRIES];
    logic [RAM_ADDR_WIDTH-1:0] tbl_addr  [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0]     tbl_wdata [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0]     tbl_rdata [NUM_ENTRIES];
    logic [1:0]                exp_kind;
    logic [RAM_ADDR_WIDTH-1:0] exp_addr;
    logic [DATA_WIDTH-1:0]     exp_wdata;
    logic [DATA_WIDTH-1:0]     exp_rdata;
    int                        seed;
    int                        cycles;
    int                        errors;
    int                        frames;

    pet_bridge_top pet_bridge_top_i (.*);

    bridge_checker watcher (
        .clock_i (clock_i), .rst_n_i (rst_n_i),
        .spi_cs_n_i (spi_cs_n_i), .spi_sck_i (spi_sck_i),
        .spi_sd_i (spi_sd_o), .spi_stall_i (spi_stall_o),
        .ram_addr_i (ram_addr_o), .ram_data_i (ram_data_o),
        .ram_data_oe_i (ram_data_oe_o), .ram_oe_i (ram_oe_o),
        .ram_we_i (ram_we_o), .status_i (status_o),
        .exp_kind_i (exp_kind), .exp_addr_i (exp_addr),
        .exp_wdata_i (exp_wdata), .exp_rdata_i (exp_rdata),
        .error_cnt_o (errors), .frame_cnt_o (frames)
    );

    function automatic logic [DATA_WIDTH-1:0] fill_byte(input logic [RAM_ADDR_WIDTH-1:0] a);
        return a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h5a;
    endfunction

    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    // SRAM model written while we is high
    initial begin
        for (int a = 0; a < 2**RAM_ADDR_WIDTH; a++) begin
            sram[a] = fill_byte(RAM_ADDR_WIDTH'(a));
        end
        forever begin
            @(posedge clock_i);
            if (ram_we_o) sram[ram_addr_o] = ram_data_o;
        end
    end

    assign ram_data_i = ram_oe_o ? sram[ram_addr_o] : '0;

    always @(posedge clock_i) begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock_i);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            spi_sd_i = b[i];
            wait_clocks(HALF_SCK);
            spi_sck_i = 1'b1;
            wait_clocks(HALF_SCK);
            spi_sck_i = 1'b0;
        end
    endtask

    task automatic wait_stall_low();
        while (spi_stall_o) wait_clocks(1);
    endtask

    task automatic add_entry(input int idx, input logic [1:0] kind,
                             input logic [RAM_ADDR_WIDTH-1:0] addr);
        tbl_kind[idx]  = kind;
        tbl_addr[idx]  = addr;
        tbl_wdata[idx] = 8'($random(seed));
        if (kind == KIND_WRITE) shadow[addr] = tbl_wdata[idx];
        tbl_rdata[idx] = shadow[addr];
    endtask

    task automatic run_frame(input int idx);
        logic [7:0] cmd;
        cmd = {tbl_kind[idx] != KIND_READ, 6'b0, tbl_addr[idx][16]};
        spi_cs_n_i = 1'b0;
        wait_clocks(HALF_SCK);
        send_byte(cmd);
        send_byte(tbl_addr[idx][15:8]);
        if (tbl_kind[idx] != KIND_ABORT) begin
            send_byte(tbl_addr[idx][7:0]);
            if (tbl_kind[idx] == KIND_WRITE) send_byte(tbl_wdata[idx]);
            wait_clocks(HALF_SCK);
            wait_stall_low();
            if (tbl_kind[idx] == KIND_READ) send_byte(8'h00);  // Reply slot
        end
        wait_clocks(HALF_SCK);
        spi_cs_n_i = 1'b1;
        wait_clocks(HALF_SCK);
    endtask

    initial begin
        seed = 32'h17c8_e444;
        cycles = 0;
        rst_n_i = 1'b0;
        spi_cs_n_i = 1'b1;
        spi_sck_i = 1'b0;
        spi_sd_i = 1'b0;
        exp_kind = KIND_ABORT;
        exp_addr = '0;
        exp_wdata = '0;
        exp_rdata = '0;
        for (int a = 0; a < 2**RAM_ADDR_WIDTH; a++) begin
            shadow[a] = fill_byte(RAM_ADDR_WIDTH'(a));
        end
        add_entry(0, KIND_WRITE, 17'h00123);
        add_entry(1, KIND_WRITE, 17'h1abcd);   // Address bit 16 set
        add_entry(2, KIND_READ,  17'h00123);
        add_entry(3, KIND_READ,  17'h1abcd);
        add_entry(4, KIND_ABORT, 17'h05555);
        add_entry(5, KIND_WRITE, 17'h05555);
        add_entry(6, KIND_READ,  17'h05555);
        add_entry(7, KIND_WRITE, 17'h00123);   // Overwrite
        add_entry(8, KIND_READ,  17'h00123);
        add_entry(9, KIND_READ,  17'h1ffff);   // Never written
        wait_clocks(2);
        rst_n_i = 1'b1;
        wait_clocks(4);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            exp_kind  = tbl_kind[i];
            exp_addr  = tbl_addr[i];
            exp_wdata = tbl_wdata[i];
            exp_rdata = tbl_rdata[i];
            run_frame(i);
        end
        wait_clocks(10);
        $display("Summary: %0d frames checked, %0d errors", frames, errors);
        if (errors == 0 && frames == NUM_ENTRIES) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/bus_pkg.sv
common/spi_cmd_pkg.sv
common/mem_bus_if.sv
rtl/spi/spi_target.sv
rtl/spi/spi_cmd_decoder.sv
rtl/bus/bus_arbiter.sv
rtl/bus/sram_controller.sv
rtl/pet_bridge_top.sv
verification/bridge_checker.sv
verification/tb_pet_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_pet_bridge -f verilog.f -o Vtb_pet_bridge
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_pet_bridge > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -q "test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
